//--- src/gfx_vga_config.svh
`ifndef GFX_VGA_CONFIG_SVH
`define GFX_VGA_CONFIG_SVH

// Coordinate and mode field widths
`define GFX_H_WIDTH 10
`define GFX_V_WIDTH 10

// RGB 4:4:4 pixel word
`define GFX_PIXEL_WIDTH 12
`define GFX_COLOR_WIDTH 4

// Row-major framebuffer geometry
`define FB_COLS 32
`define FB_ROWS 16

// Total words in the framebuffer
`define FB_DEPTH (`FB_COLS * `FB_ROWS)

// Enough to cover FB_COLS x FB_ROWS
`define FB_ADDR_WIDTH 9

`endif

//--- src/gfx_pkg.sv
`include "gfx_vga_config.svh"

package gfx_pkg;

  typedef struct packed {
    logic [`GFX_H_WIDTH-1:0]     x;
    logic [`GFX_V_WIDTH-1:0]     y;
    logic [`GFX_PIXEL_WIDTH-1:0] pixel;
  } gfx_pixel_t;

  // Visible is a size while line_end and frame_end are total minus one
  typedef struct packed {
    logic [`GFX_H_WIDTH-1:0] h_visible;
    logic [`GFX_H_WIDTH-1:0] h_sync_start;
    logic [`GFX_H_WIDTH-1:0] h_sync_end;
    logic [`GFX_H_WIDTH-1:0] h_line_end;
    logic [`GFX_V_WIDTH-1:0] v_visible;
    logic [`GFX_V_WIDTH-1:0] v_sync_start;
    logic [`GFX_V_WIDTH-1:0] v_sync_end;
    logic [`GFX_V_WIDTH-1:0] v_frame_end;
  } vga_mode_t;

  typedef struct packed {
    logic                        en;
    logic [`FB_ADDR_WIDTH-1:0]   addr;
    logic [`GFX_PIXEL_WIDTH-1:0] data;
  } fb_wr_t;

  typedef struct packed {
    logic [`GFX_H_WIDTH-1:0] x;
    logic [`GFX_V_WIDTH-1:0] y;
    logic                    visible;
    logic                    hsync;
    logic                    vsync;
  } scan_pos_t;

  typedef struct packed {
    logic [`GFX_COLOR_WIDTH-1:0] red;
    logic [`GFX_COLOR_WIDTH-1:0] grn;
    logic [`GFX_COLOR_WIDTH-1:0] blu;
    logic                        hsync;
    logic                        vsync;
  } vga_out_t;

  typedef enum logic [1:0] {
    FB_IDLE,
    FB_CLEAR,
    FB_RUN
  } fb_state_e;

endpackage

//--- src/vga_timing.sv
`include "gfx_vga_config.svh"

module vga_timing
  import gfx_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      run,
  input  vga_mode_t mode,
  output scan_pos_t pos
);

  logic [`GFX_H_WIDTH-1:0] x;
  logic [`GFX_V_WIDTH-1:0] y;
  logic                    in_hsync;
  logic                    in_vsync;
  logic                    line_wrap;
  logic                    frame_wrap;

  assign line_wrap  = (x == mode.h_line_end);
  assign frame_wrap = (y == mode.v_frame_end);

  // Held at the origin until scan-out starts
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      x <= '0;
      y <= '0;
    end else if (!run) begin
      x <= '0;
      y <= '0;
    end else if (line_wrap) begin
      x <= '0;
      if (frame_wrap) begin
        y <= '0;
      end else begin
        y <= y + 1'b1;
      end
    end else begin
      x <= x + 1'b1;
    end
  end

  // Sync window is start inclusive, end exclusive
  assign in_hsync = (x >= mode.h_sync_start) && (x < mode.h_sync_end);
  assign in_vsync = (y >= mode.v_sync_start) && (y < mode.v_sync_end);

  assign pos.x       = x;
  assign pos.y       = y;
  assign pos.visible = run && (x < mode.h_visible) && (y < mode.v_visible);

  // Syncs are active low and stay inactive while stopped
  assign pos.hsync = !(run && in_hsync);
  assign pos.vsync = !(run && in_vsync);

  // Visible area must map onto the framebuffer
  a_mode_fits: assert property (
    @(posedge clk) disable iff (!rst_n)
    run |-> (mode.h_visible <= `GFX_H_WIDTH'(`FB_COLS)) &&
            (mode.v_visible <= `GFX_V_WIDTH'(`FB_ROWS))
  );

endmodule

//--- src/fb_ram.sv
`include "gfx_vga_config.svh"

module fb_ram
  import gfx_pkg::*;
(
  input  logic                        clk,
  input  fb_wr_t                      wr,
  input  logic [`FB_ADDR_WIDTH-1:0]   rd_addr,
  output logic [`GFX_PIXEL_WIDTH-1:0] rd_data
);

  logic [`GFX_PIXEL_WIDTH-1:0] mem [`FB_DEPTH];

  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Read before write on a same-address collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

//--- src/fb_writer.sv
`include "gfx_vga_config.svh"

module fb_writer
  import gfx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,
  input  vga_mode_t  mode,
  input  logic       gfx_valid,
  input  gfx_pixel_t gfx,
  output logic       gfx_ready,
  output fb_wr_t     client_wr,
  output logic       oob_drop
);

  logic                      accept;
  logic                      in_bounds;
  logic [`FB_ADDR_WIDTH-1:0] wr_addr;

  // Never stalls once scan-out is running
  assign gfx_ready = run;
  assign accept    = gfx_valid && gfx_ready;

  assign in_bounds = (gfx.x < mode.h_visible) && (gfx.y < mode.v_visible);
  assign wr_addr   = `FB_ADDR_WIDTH'(gfx.y * `FB_COLS + gfx.x);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      client_wr.en <= 1'b0;
      oob_drop     <= 1'b0;
    end else begin
      client_wr.en <= accept && in_bounds;
      oob_drop     <= accept && !in_bounds;
    end
    if (accept) begin
      client_wr.addr <= wr_addr;
      client_wr.data <= gfx.pixel;
    end
  end

  a_wr_or_drop: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(client_wr.en && oob_drop)
  );

endmodule

//--- src/fb_scanout.sv
`include "gfx_vga_config.svh"

module fb_scanout
  import gfx_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_n,
  input  scan_pos_t                   pos,
  output logic [`FB_ADDR_WIDTH-1:0]   rd_addr,
  input  logic [`GFX_PIXEL_WIDTH-1:0] rd_data,
  output vga_out_t                    vga
);

  localparam int CW = `GFX_COLOR_WIDTH;

  logic visible_d;
  logic hsync_d;
  logic vsync_d;

  assign rd_addr = `FB_ADDR_WIDTH'(pos.y * `FB_COLS + pos.x);

  // Matches the one-cycle RAM read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      visible_d <= 1'b0;
      hsync_d   <= 1'b1;
      vsync_d   <= 1'b1;
    end else begin
      visible_d <= pos.visible;
      hsync_d   <= pos.hsync;
      vsync_d   <= pos.vsync;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      vga.red   <= '0;
      vga.grn   <= '0;
      vga.blu   <= '0;
      vga.hsync <= 1'b1;
      vga.vsync <= 1'b1;
    end else begin
      vga.hsync <= hsync_d;
      vga.vsync <= vsync_d;
      if (visible_d) begin
        vga.red <= rd_data[3*CW-1 -: CW];
        vga.grn <= rd_data[2*CW-1 -: CW];
        vga.blu <= rd_data[CW-1:0];
      end else begin
        // Blanking
        vga.red <= '0;
        vga.grn <= '0;
        vga.blu <= '0;
      end
    end
  end

endmodule

//--- src/fb_ctrl.sv
`include "gfx_vga_config.svh"

module fb_ctrl
  import gfx_pkg::*;
(
  input  logic   clk,
  input  logic   rst_n,
  input  logic   fb_start,
  input  fb_wr_t client_wr,
  input  logic   oob_drop,
  output logic   run,
  output fb_wr_t ram_wr,
  output logic   error
);

  localparam logic [`FB_ADDR_WIDTH:0] FB_SIZE = (`FB_ADDR_WIDTH + 1)'(`FB_DEPTH);

  fb_state_e               state;
  logic [`FB_ADDR_WIDTH:0] clr_cnt;
  logic                    clr_last;

  assign clr_last = (clr_cnt == FB_SIZE - 1'b1);

  // A start pulse restarts the clear from any state
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= FB_IDLE;
      run     <= 1'b0;
      clr_cnt <= '0;
    end else if (fb_start) begin
      state   <= FB_CLEAR;
      run     <= 1'b0;
      clr_cnt <= '0;
    end else if (state == FB_CLEAR) begin
      clr_cnt <= clr_cnt + 1'b1;
      if (clr_last) begin
        state <= FB_RUN;
        run   <= 1'b1;
      end
    end
  end

  // Clear writes own the RAM port until scan-out starts
  always_comb begin
    case (state)
      FB_CLEAR: begin
        ram_wr.en   = 1'b1;
        ram_wr.addr = clr_cnt[`FB_ADDR_WIDTH-1:0];
        ram_wr.data = '0;
      end
      FB_RUN: begin
        ram_wr = client_wr;
      end
      default: begin
        ram_wr    = client_wr;
        ram_wr.en = 1'b0;
      end
    endcase
  end

  // Sticky until the next start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      error <= 1'b0;
    end else if (fb_start) begin
      error <= 1'b0;
    end else if (oob_drop) begin
      error <= 1'b1;
    end
  end

  a_no_clear_in_run: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(state == FB_CLEAR && run)
  );

  a_clr_cnt_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    clr_cnt <= FB_SIZE
  );

endmodule

//--- src/gfx_vga.sv
`include "gfx_vga_config.svh"

module gfx_vga
  import gfx_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       fb_start,
  input  vga_mode_t  mode,
  input  logic       gfx_valid,
  input  gfx_pixel_t gfx,
  output logic       gfx_ready,
  output vga_out_t   vga,
  output logic       vga_error
);

  logic                        run;
  logic                        oob_drop;
  fb_wr_t                      client_wr;
  fb_wr_t                      ram_wr;
  scan_pos_t                   pos;
  logic [`FB_ADDR_WIDTH-1:0]   rd_addr;
  logic [`GFX_PIXEL_WIDTH-1:0] rd_data;

  fb_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .fb_start (fb_start),
    .client_wr(client_wr),
    .oob_drop (oob_drop),
    .run      (run),
    .ram_wr   (ram_wr),
    .error    (vga_error)
  );

  vga_timing u_timing (
    .clk  (clk),
    .rst_n(rst_n),
    .run  (run),
    .mode (mode),
    .pos  (pos)
  );

  fb_writer u_writer (
    .clk      (clk),
    .rst_n    (rst_n),
    .run      (run),
    .mode     (mode),
    .gfx_valid(gfx_valid),
    .gfx      (gfx),
    .gfx_ready(gfx_ready),
    .client_wr(client_wr),
    .oob_drop (oob_drop)
  );

  fb_ram u_ram (
    .clk    (clk),
    .wr     (ram_wr),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  fb_scanout u_scanout (
    .clk    (clk),
    .rst_n  (rst_n),
    .pos    (pos),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .vga    (vga)
  );

endmodule

//--- bench/gfx_vga_tb.sv
`include "gfx_vga_config.svh"

module gfx_vga_tb
  import gfx_pkg::*;
();

  // Small test mode with 16x12 visible in a 24x16 frame
  localparam int H_VIS     = 16;
  localparam int H_SYNC_S  = 18;
  localparam int H_SYNC_E  = 20;
  localparam int H_END     = 23;
  localparam int V_VIS     = 12;
  localparam int V_SYNC_S  = 13;
  localparam int V_SYNC_E  = 14;
  localparam int V_END     = 15;
  localparam int FRAME_LEN = (H_END + 1) * (V_END + 1);

  localparam int CLEAR_CYCLES  = `FB_DEPTH + 1;
  localparam int TEST_FRAMES   = 7;
  localparam int WATCHDOG_TIME = TEST_FRAMES * FRAME_LEN * 10 + 4 * CLEAR_CYCLES * 10;

  localparam vga_out_t IDLE_PINS = '{red: '0, grn: '0, blu: '0, hsync: 1'b1, vsync: 1'b1};

  // One accepted word on its way to the RAM
  typedef struct packed {
    logic                        wr;
    logic                        oob;
    logic [`FB_ADDR_WIDTH-1:0]   addr;
    logic [`GFX_PIXEL_WIDTH-1:0] data;
  } pend_t;

  logic       clk = 1'b0;
  logic       rst_n;
  logic       fb_start;
  vga_mode_t  mode;
  logic       gfx_valid;
  gfx_pixel_t gfx;
  logic       gfx_ready;
  vga_out_t   vga;
  logic       vga_error;

  integer seed = 32'h1c59;
  int     errors = 0;
  int     checks = 0;
  int     tests = 0;
  int     n_writes = 0;

  logic [`GFX_PIXEL_WIDTH-1:0] model_fb [`FB_DEPTH];
  logic                        model_err;
  pend_t                       stage1;
  pend_t                       stage2;
  vga_out_t                    exp_d1;
  vga_out_t                    exp_d2;
  int                          sx;
  int                          sy;

  gfx_vga DUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .fb_start (fb_start),
    .mode     (mode),
    .gfx_valid(gfx_valid),
    .gfx      (gfx),
    .gfx_ready(gfx_ready),
    .vga      (vga),
    .vga_error(vga_error)
  );

  always #5 clk = ~clk;

  task automatic check_value(input string name, input int got, input int expected);
    checks++;
    assert (got == expected) else begin
      errors++;
      $display("ERROR at time %0t: %s = %0h, expected %0h", $time, name, got, expected);
    end
  endtask

  task automatic end_test(input string name, input int err_before);
    tests++;
    $display("test %0d %-14s %s, %0d errors", tests, name,
             (errors == err_before) ? "ok" : "failed", errors - err_before);
  endtask

  task automatic wait_frames(input int n);
    repeat (n * FRAME_LEN + 4) @(posedge clk);
  endtask

  // Pulse fb_start and time the clear up to the rise of gfx_ready
  task automatic start_and_clear();
    int cycles;
    @(posedge clk);
    fb_start  <= 1'b1;
    gfx_valid <= 1'b0;
    @(posedge clk);
    fb_start <= 1'b0;
    cycles = 1;
    @(negedge clk);
    while (!gfx_ready && cycles < CLEAR_CYCLES + 16) begin
      cycles++;
      @(negedge clk);
    end
    assert (gfx_ready) else begin
      errors++;
      $display("gfx_ready never rose after fb_start at time %0t", $time);
    end
    if (gfx_ready) begin
      check_value("clear cycles", cycles, CLEAR_CYCLES);
    end
  endtask

  task automatic drive_random_writes(input int cycles);
    logic [31:0] rnd;
    logic [31:0] rnd_px;
    repeat (cycles) begin
      @(posedge clk);
      rnd    = $random(seed);
      rnd_px = $random(seed);
      gfx_valid <= rnd[0];
      gfx.x     <= `GFX_H_WIDTH'(int'(rnd[15:8]) % H_VIS);
      gfx.y     <= `GFX_V_WIDTH'(int'(rnd[23:16]) % V_VIS);
      gfx.pixel <= rnd_px[`GFX_PIXEL_WIDTH-1:0];
    end
    @(posedge clk);
    gfx_valid <= 1'b0;
  endtask

  // Off the right edge or below the last visible line
  task automatic drive_oob_write();
    logic [31:0] rnd;
    @(posedge clk);
    rnd = $random(seed);
    gfx_valid <= 1'b1;
    gfx.pixel <= rnd[`GFX_PIXEL_WIDTH-1:0];
    if (rnd[31]) begin
      gfx.x <= `GFX_H_WIDTH'(H_VIS + int'(rnd[19:12]));
      gfx.y <= `GFX_V_WIDTH'(int'(rnd[27:20]) % V_VIS);
    end else begin
      gfx.x <= `GFX_H_WIDTH'(int'(rnd[19:12]) % H_VIS);
      gfx.y <= `GFX_V_WIDTH'(V_VIS + int'(rnd[27:20]));
    end
    @(posedge clk);
    gfx_valid <= 1'b0;
  endtask

  // Framebuffer and scan model with pins compared two cycles after the position
  always @(negedge clk) begin
    logic                        acc;
    logic                        in_bounds;
    logic [`GFX_PIXEL_WIDTH-1:0] px;
    vga_out_t                    exp_now;
    if (!rst_n) begin
      foreach (model_fb[i]) model_fb[i] = '0;
      model_err = 1'b0;
      stage1    = '0;
      stage2    = '0;
      exp_d1    = IDLE_PINS;
      exp_d2    = IDLE_PINS;
      sx        = 0;
      sy        = 0;
    end else begin
      if (stage2.wr) model_fb[stage2.addr] = stage2.data;
      if (stage2.oob) model_err = 1'b1;
      check_value("vga.red", int'(vga.red), int'(exp_d2.red));
      check_value("vga.grn", int'(vga.grn), int'(exp_d2.grn));
      check_value("vga.blu", int'(vga.blu), int'(exp_d2.blu));
      check_value("vga.hsync", int'(vga.hsync), int'(exp_d2.hsync));
      check_value("vga.vsync", int'(vga.vsync), int'(exp_d2.vsync));
      check_value("vga_error", int'(vga_error), int'(model_err));

      acc         = gfx_valid && gfx_ready;
      in_bounds   = (int'(gfx.x) < H_VIS) && (int'(gfx.y) < V_VIS);
      stage2      = stage1;
      stage1.wr   = acc && in_bounds;
      stage1.oob  = acc && !in_bounds;
      stage1.addr = `FB_ADDR_WIDTH'(int'(gfx.y) * `FB_COLS + int'(gfx.x));
      stage1.data = gfx.pixel;
      if (acc && in_bounds) n_writes++;

      exp_now = IDLE_PINS;
      if (gfx_ready) begin
        exp_now.hsync = !(sx >= H_SYNC_S && sx < H_SYNC_E);
        exp_now.vsync = !(sy >= V_SYNC_S && sy < V_SYNC_E);
        if (sx < H_VIS && sy < V_VIS) begin
          px = model_fb[`FB_ADDR_WIDTH'(sy * `FB_COLS + sx)];
          exp_now.red = px[11:8];
          exp_now.grn = px[7:4];
          exp_now.blu = px[3:0];
        end
        if (sx == H_END) begin
          sx = 0;
          sy = (sy == V_END) ? 0 : sy + 1;
        end else begin
          sx = sx + 1;
        end
      end else begin
        sx = 0;
        sy = 0;
      end
      exp_d2 = exp_d1;
      exp_d1 = exp_now;

      // Start wipes the framebuffer and the sticky error
      if (fb_start) begin
        foreach (model_fb[i]) model_fb[i] = '0;
        model_err = 1'b0;
        stage1    = '0;
        stage2    = '0;
      end
    end
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired after %0d time units, the tests did not finish", WATCHDOG_TIME);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    int e0;
    rst_n     = 1'b0;
    fb_start  = 1'b0;
    gfx_valid = 1'b0;
    gfx       = '0;
    mode.h_visible    = `GFX_H_WIDTH'(H_VIS);
    mode.h_sync_start = `GFX_H_WIDTH'(H_SYNC_S);
    mode.h_sync_end   = `GFX_H_WIDTH'(H_SYNC_E);
    mode.h_line_end   = `GFX_H_WIDTH'(H_END);
    mode.v_visible    = `GFX_V_WIDTH'(V_VIS);
    mode.v_sync_start = `GFX_V_WIDTH'(V_SYNC_S);
    mode.v_sync_end   = `GFX_V_WIDTH'(V_SYNC_E);
    mode.v_frame_end  = `GFX_V_WIDTH'(V_END);
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    e0 = errors;
    @(negedge clk);
    check_value("gfx_ready", int'(gfx_ready), 0);
    check_value("vga.red", int'(vga.red), 0);
    check_value("vga.grn", int'(vga.grn), 0);
    check_value("vga.blu", int'(vga.blu), 0);
    check_value("vga.hsync", int'(vga.hsync), 1);
    check_value("vga.vsync", int'(vga.vsync), 1);
    check_value("vga_error", int'(vga_error), 0);
    end_test("reset", e0);

    e0 = errors;
    start_and_clear();
    wait_frames(1);
    end_test("clear", e0);

    e0 = errors;
    wait_frames(2);
    end_test("sync", e0);

    e0 = errors;
    drive_random_writes(300);
    wait_frames(1);
    end_test("random writes", e0);

    e0 = errors;
    drive_oob_write();
    wait_frames(1);
    @(negedge clk);
    check_value("vga_error", int'(vga_error), 1);
    start_and_clear();
    check_value("vga_error", int'(vga_error), 0);
    wait_frames(1);
    end_test("out of bounds", e0);

    $display("%0d tests, %0d checks, %0d errors, %0d pixel writes",
             tests, checks, errors, n_writes);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- gfx_vga.f
+incdir+src
src/gfx_pkg.sv
src/vga_timing.sv
src/fb_ram.sv
src/fb_writer.sv
src/fb_scanout.sv
src/fb_ctrl.sv
src/gfx_vga.sv
bench/gfx_vga_tb.sv

//--- run.sh
#!/bin/sh
# Build the gfx_vga testbench with Verilator, run it and scan the log for the result
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f gfx_vga.f --top-module gfx_vga_tb \
    -Mdir obj_dir -o sim_gfx_vga \
  && ./obj_dir/sim_gfx_vga | tee sim.log \
  || { echo "build or run of the testbench failed"; exit 1; }

grep -qx "Simulation PASSED" sim.log \
  && echo "run.sh: testbench passed" \
  || { echo "run.sh: testbench failed, see sim.log"; exit 1; }
